/* sim.f */
+incdir+logic
logic/imsic_pkg.sv
logic/imsic_ifs.sv
logic/imsic_csr_decode.sv
logic/imsic_intp_files.sv
logic/imsic_irq_select.sv
logic/imsic_csr_top.sv
sim/tb_imsic.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module tb_imsic -Mdir obj_dir

status=0
./obj_dir/Vtb_imsic > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi

/* sim/tb_imsic.sv */
// IMSIC interrupt file testbench
`timescale 1ns/1ps
`default_nettype none

`include "imsic_config.svh"

module tb_imsic;
    import imsic_pkg::*;

    localparam int WAIT_LIMIT = 16;     // cycles allowed for a read valid

    logic       clk;
    logic       rstn;
    logic       i_csr_wr;
    logic       i_csr_rd;
    csr_addr_t  i_csr_addr;
    logic       i_csr_v;
    logic       i_priv_illegal;
    logic [2:0] i_file_sel;
    xlen_t      i_csr_wdata;
    vgein_t     i_vgein;
    logic       o_csr_rdata_vld;
    xlen_t      o_csr_rdata;
    logic       o_csr_illegal;
    logic [2:0] o_irq;
    topei_t     o_mtopei;
    topei_t     o_stopei;
    topei_t     o_vstopei;

    // reference copy of the four files
    logic  m_delivery  [`IMSIC_NR_FILES];
    xlen_t m_threshold [`IMSIC_NR_FILES];
    xlen_t m_eip       [`IMSIC_NR_FILES];
    xlen_t m_eie       [`IMSIC_NR_FILES];
    xlen_t m_rdata;                     // value of the last legal read

    csr_addr_t reg_addr [4] = '{`IMSIC_EIDELIVERY, `IMSIC_EITHRESHOLD,
                                `IMSIC_EIP0, `IMSIC_EIE0};
    vgein_t    vg_order [4] = '{6'd1, 6'd2, 6'd0, 6'd3};
    integer    seed;
    int        errors;
    int        checks;
    xlen_t     rnd;

    imsic_csr_top DUT (.*);

    function automatic csr_kind_e kind_of(csr_addr_t addr);
        csr_kind_e k;
        case (addr)
            `IMSIC_EIDELIVERY:  k = kind_delivery;
            `IMSIC_EITHRESHOLD: k = kind_threshold;
            `IMSIC_EIP0:        k = kind_eip;
            `IMSIC_EIE0:        k = kind_eie;
            default: begin
                k = (addr >= `IMSIC_IPRIO_LO && addr <= `IMSIC_IPRIO_HI) ? kind_iprio : kind_none;
            end
        endcase
        return k;
    endfunction

    function automatic bit model_legal(csr_kind_e k, logic [2:0] file, bit v, bit priv);
        return !priv && (file < 3'd4) && !(k == kind_iprio && v) && (k != kind_none);
    endfunction

    function automatic xlen_t model_value(csr_kind_e k, int f);
        case (k)
            kind_delivery:  return {31'd0, m_delivery[f]};
            kind_threshold: return m_threshold[f];
            kind_eip:       return m_eip[f];
            kind_eie:       return m_eie[f];
            default:        return '0;      // iprio has no storage here
        endcase
    endfunction

    function automatic void model_write(csr_kind_e k, int f, xlen_t d);
        case (k)
            kind_delivery:  m_delivery[f] = d[0];
            kind_threshold: m_threshold[f] = d;
            kind_eip:       m_eip[f] = d & ~32'd1;
            kind_eie:       m_eie[f] = d;
            default:        ;
        endcase
    endfunction

    // lowest identity pending and enabled under the threshold or 0
    function automatic int lowest_id(int f);
        int id;
        id = 0;
        for (int j = 1; j < `IMSIC_XLEN; j++) begin
            if (id == 0 && m_eip[f][j] && m_eie[f][j] &&
                (m_threshold[f] == 0 || j < m_threshold[f])) begin
                id = j;
            end
        end
        return id;
    endfunction

    function automatic topei_t topei_of(int id);
        topei_t t;
        t        = '0;
        t[26:16] = 11'(id);
        t[10:0]  = 11'(id);
        return t;
    endfunction

    task automatic compare_word(string name, xlen_t got, xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic [2:0] exp_irq;
        topei_t     exp_vs;
        int         vf;
        exp_irq[0] = m_delivery[0] && (lowest_id(0) != 0);
        exp_irq[1] = m_delivery[1] && (lowest_id(1) != 0);
        exp_irq[2] = 1'b0;
        exp_vs     = '0;
        if (i_vgein != 0 && int'(i_vgein) <= `IMSIC_NR_VS) begin
            vf         = int'(i_vgein) + 1;
            exp_irq[2] = m_delivery[vf] && (lowest_id(vf) != 0);
            exp_vs     = topei_of(lowest_id(vf));
        end
        compare_word("o_irq", 32'(o_irq), 32'(exp_irq));
        compare_word("o_mtopei", o_mtopei, topei_of(lowest_id(0)));
        compare_word("o_stopei", o_stopei, topei_of(lowest_id(1)));
        compare_word("o_vstopei", o_vstopei, exp_vs);
    endtask

    task automatic abort_on_timeout(string what);
        errors++;
        $display("timeout: %s", what);
        $display("closing: %0d errors in %0d checks", errors, checks);
        $display("Checks failed");
        $finish;
    endtask

    // one strobe driven on a falling edge and checked one cycle later
    task automatic csr_access(bit wr, csr_addr_t addr, logic [2:0] file, xlen_t wdata,
                              bit v, bit priv);
        csr_kind_e k;
        bit        legal;
        int        waited;
        k              = kind_of(addr);
        legal          = model_legal(k, file, v, priv);
        i_csr_wr       = wr;
        i_csr_rd       = !wr;
        i_csr_addr     = addr;
        i_file_sel     = file;
        i_csr_wdata    = wdata;
        i_csr_v        = v;
        i_priv_illegal = priv;
        @(negedge clk);
        i_csr_wr = 1'b0;
        i_csr_rd = 1'b0;
        waited   = 1;
        while (!wr && !o_csr_rdata_vld && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wr && !o_csr_rdata_vld) begin
            abort_on_timeout("no read valid after a read strobe");
        end else begin
            assert (waited == 1) else begin
                errors++;
                $display("read valid arrived %0d cycles after the read strobe", waited);
            end
            compare_word("o_csr_illegal", 32'(o_csr_illegal), 32'(!legal));
            compare_word("o_csr_rdata_vld", 32'(o_csr_rdata_vld), 32'(!wr));
            if (legal && wr) begin
                model_write(k, int'(file[1:0]), wdata);
            end else if (legal) begin
                m_rdata = model_value(k, int'(file[1:0]));
            end
            if (!wr) begin
                compare_word("o_csr_rdata", o_csr_rdata, m_rdata);
            end
            check_outputs();
        end
    endtask

    task automatic random_access();
        csr_addr_t  addr;
        logic [2:0] file;
        rnd = $random(seed);
        case (rnd[6:4])
            3'd4:    addr = {8'h03, rnd[11:8]};            // iprio window
            3'd5:    addr = rnd[7] ? 12'h0C1 : 12'h081;    // eie1 / eip1
            3'd6:    addr = rnd[31:20];
            3'd7:    addr = `IMSIC_EIP0;
            default: addr = reg_addr[rnd[5:4]];
        endcase
        file = (rnd[14:12] == 3'd7) ? {1'b1, rnd[16:15]} : {1'b0, rnd[13:12]};
        if (rnd[26:24] == 3'd0) begin
            i_vgein = {4'd0, rnd[28:27]};
        end
        csr_access(rnd[22], addr, file, $random(seed), rnd[17], rnd[21:18] == 4'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        seed           = 32'he58b;
        errors         = 0;
        checks         = 0;
        rstn           = 1'b0;
        i_csr_wr       = 1'b0;
        i_csr_rd       = 1'b0;
        i_csr_addr     = '0;
        i_csr_v        = 1'b0;
        i_priv_illegal = 1'b0;
        i_file_sel     = '0;
        i_csr_wdata    = '0;
        i_vgein        = 6'd1;
        m_rdata        = '0;
        for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
            m_delivery[f]  = 1'b0;
            m_threshold[f] = '0;
            m_eip[f]       = '0;
            m_eie[f]       = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_outputs();

        // everything reads zero after reset
        for (int f = 0; f < 4; f++) begin
            foreach (reg_addr[a]) csr_access(1'b0, reg_addr[a], 3'(f), '0, 1'b0, 1'b0);
        end

        // write then read back
        for (int f = 0; f < 4; f++) begin
            foreach (reg_addr[a]) begin
                csr_access(1'b1, reg_addr[a], 3'(f), $random(seed), 1'b0, 1'b0);
                csr_access(1'b0, reg_addr[a], 3'(f), '0, 1'b0, 1'b0);
            end
        end

        // rejected accesses in both directions
        for (int w = 0; w < 2; w++) begin
            csr_access(w[0], `IMSIC_EIE0, 3'd1, $random(seed), 1'b0, 1'b1);
            csr_access(w[0], 12'h071, 3'd0, $random(seed), 1'b0, 1'b0);
            csr_access(w[0], 12'h081, 3'd0, $random(seed), 1'b0, 1'b0);
            csr_access(w[0], 12'h0C1, 3'd2, $random(seed), 1'b0, 1'b0);
            csr_access(w[0], 12'h035, 3'd2, $random(seed), 1'b1, 1'b0);
            csr_access(w[0], `IMSIC_EIP0, 3'd4, $random(seed), 1'b0, 1'b0);
            csr_access(w[0], `IMSIC_EITHRESHOLD, 3'd7, $random(seed), 1'b0, 1'b0);
        end
        for (int f = 0; f < 4; f++) begin
            foreach (reg_addr[a]) csr_access(1'b0, reg_addr[a], 3'(f), '0, 1'b0, 1'b0);
        end

        // top interrupt with small thresholds
        repeat (30) begin
            for (int f = 0; f < 4; f++) begin
                rnd = $random(seed);
                csr_access(1'b1, `IMSIC_EITHRESHOLD, 3'(f), {26'd0, rnd[5:0]}, 1'b0, 1'b0);
                csr_access(1'b1, `IMSIC_EIP0, 3'(f), $random(seed), 1'b0, 1'b0);
                csr_access(1'b1, `IMSIC_EIE0, 3'(f), $random(seed), 1'b0, 1'b0);
                csr_access(1'b1, `IMSIC_EIDELIVERY, 3'(f), {31'd0, rnd[8]}, 1'b0, 1'b0);
            end
        end

        // guest files 2 and 3 get ids 6 and 9
        for (int f = 2; f < 4; f++) begin
            csr_access(1'b1, `IMSIC_EITHRESHOLD, 3'(f), '0, 1'b0, 1'b0);
            csr_access(1'b1, `IMSIC_EIP0, 3'(f), xlen_t'(1) << (3 * f), 1'b0, 1'b0);
            csr_access(1'b1, `IMSIC_EIE0, 3'(f), '1, 1'b0, 1'b0);
            csr_access(1'b1, `IMSIC_EIDELIVERY, 3'(f), 32'd1, 1'b0, 1'b0);
        end
        foreach (vg_order[i]) begin
            i_vgein = vg_order[i];
            @(negedge clk);
            check_outputs();
        end

        repeat (600) random_access();

        $display("closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/imsic_csr_top.sv */
// IMSIC interrupt file block
`timescale 1ns/1ps
`default_nettype none

module imsic_csr_top (
    input  wire                  clk,
    input  wire                  rstn,
    // indirect csr access
    input  wire                  i_csr_wr,
    input  wire                  i_csr_rd,
    input  imsic_pkg::csr_addr_t i_csr_addr,
    input  wire                  i_csr_v,
    input  wire                  i_priv_illegal,
    input  wire [2:0]            i_file_sel,
    input  imsic_pkg::xlen_t     i_csr_wdata,
    input  imsic_pkg::vgein_t    i_vgein,
    output wire                  o_csr_rdata_vld,
    output imsic_pkg::xlen_t     o_csr_rdata,
    output wire                  o_csr_illegal,
    // to the hart
    output wire [2:0]            o_irq,
    output imsic_pkg::topei_t    o_mtopei,
    output imsic_pkg::topei_t    o_stopei,
    output imsic_pkg::topei_t    o_vstopei
);

    imsic_csr_if   u_csr_if ();
    imsic_state_if u_state_if ();

    // address and legality check
    imsic_csr_decode u_decode (
        .clk            (clk),
        .rstn           (rstn),
        .i_csr_wr       (i_csr_wr),
        .i_csr_rd       (i_csr_rd),
        .i_csr_addr     (i_csr_addr),
        .i_csr_v        (i_csr_v),
        .i_priv_illegal (i_priv_illegal),
        .i_file_sel     (i_file_sel),
        .i_csr_wdata    (i_csr_wdata),
        .o_illegal      (o_csr_illegal),
        .req            (u_csr_if.decode)
    );

    // register storage, valid follows every read strobe
    imsic_intp_files u_files (
        .clk         (clk),
        .rstn        (rstn),
        .req         (u_csr_if.files),
        .i_any_rd    (i_csr_rd),
        .o_rdata_vld (o_csr_rdata_vld),
        .o_rdata     (o_csr_rdata),
        .st          (u_state_if.files)
    );

    imsic_irq_select u_select (
        .st        (u_state_if.select),
        .i_vgein   (i_vgein),
        .o_irq     (o_irq),
        .o_mtopei  (o_mtopei),
        .o_stopei  (o_stopei),
        .o_vstopei (o_vstopei)
    );

endmodule

`default_nettype wire

/* logic/imsic_irq_select.sv */
// IMSIC top interrupt select
`timescale 1ns/1ps
`default_nettype none

`include "imsic_config.svh"

module imsic_irq_select (
    imsic_state_if.select     st,
    input  imsic_pkg::vgein_t i_vgein,
    output logic [2:0]        o_irq,
    output imsic_pkg::topei_t o_mtopei,
    output imsic_pkg::topei_t o_stopei,
    output imsic_pkg::topei_t o_vstopei
);
    import imsic_pkg::*;

    logic [`IMSIC_NR_FILES-1:0] hit;        // some identity qualifies
    logic [`IMSIC_NR_FILES-1:0] irq_file;
    intid_t                     top_id [`IMSIC_NR_FILES];
    topei_t                     topei  [`IMSIC_NR_FILES];
    vgein_t                     vs_sum;
    file_idx_t                  vs_file;
    logic                       vs_legal;

    // lowest pending and enabled identity under the threshold
    always_comb begin
        for (int k = 0; k < `IMSIC_NR_FILES; k++) begin
            hit[k]    = 1'b0;
            top_id[k] = '0;
            for (int j = `IMSIC_XLEN-1; j >= 1; j--) begin
                if (st.eip[k][j] && st.eie[k][j] &&
                    ((st.threshold[k] == '0) || (xlen_t'(j) < st.threshold[k]))) begin
                    hit[k]    = 1'b1;
                    top_id[k] = intid_t'(j); // later hits are lower ids
                end
            end
        end
    end

    for (genvar g = 0; g < `IMSIC_NR_FILES; g++) begin : g_topei
        // identity doubles as priority
        assign topei[g] = {5'd0, 11'(top_id[g]), 5'd0, 11'(top_id[g])};
    end

    assign irq_file = hit & st.delivery;

    // guest file is vgein+1 for vgein 1..NR_VS
    assign vs_sum   = i_vgein + 6'd1;
    assign vs_file  = file_idx_t'(vs_sum[1:0]);
    assign vs_legal = (i_vgein != '0) && (i_vgein <= vgein_t'(`IMSIC_NR_VS));

    assign o_irq     = {vs_legal & irq_file[vs_file], irq_file[1], irq_file[0]};
    assign o_mtopei  = topei[0];
    assign o_stopei  = topei[1];
    assign o_vstopei = vs_legal ? topei[vs_file] : '0;

    // a raised line needs delivery on and its reported identity pending and enabled
    always_comb begin
        a_irq_source: assert final (
            (!o_irq[0] || (st.delivery[0] &&
                           st.eip[0][o_mtopei[4:0]] && st.eie[0][o_mtopei[4:0]])) &&
            (!o_irq[1] || (st.delivery[1] &&
                           st.eip[1][o_stopei[4:0]] && st.eie[1][o_stopei[4:0]])) &&
            (!o_irq[2] || (st.delivery[vs_file] &&
                           st.eip[vs_file][o_vstopei[4:0]] && st.eie[vs_file][o_vstopei[4:0]]))
        ) else $error("irq raised without delivery or without a pending enabled identity");
    end

endmodule

`default_nettype wire

/* logic/imsic_intp_files.sv */
// IMSIC interrupt file registers
`timescale 1ns/1ps
`default_nettype none

`include "imsic_config.svh"

module imsic_intp_files (
    input  wire              clk,
    input  wire              rstn,
    imsic_csr_if.files       req,
    input  wire              i_any_rd,      // raw read strobe, legal or not
    output logic             o_rdata_vld,
    output imsic_pkg::xlen_t o_rdata,
    imsic_state_if.files     st
);
    import imsic_pkg::*;

    xlen_t rd_mux;

    // csr writes into the selected file
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st.delivery <= '0;
            for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
                st.threshold[f] <= '0;
                st.eip[f]       <= '0;
                st.eie[f]       <= '0;
            end
        end else if (req.wr) begin
            case (req.kind)
                kind_delivery: begin
                    st.delivery[req.file] <= req.wdata[0];
                end
                kind_threshold: begin
                    st.threshold[req.file] <= req.wdata;
                end
                kind_eip: begin
                    // identity 0 does not exist
                    st.eip[req.file] <= {req.wdata[`IMSIC_XLEN-1:1], 1'b0};
                end
                kind_eie: begin
                    st.eie[req.file] <= req.wdata;
                end
                default: ; // iprio writes are dropped
            endcase
        end
    end

    // read source by kind and file
    always_comb begin
        case (req.kind)
            kind_delivery:  rd_mux = xlen_t'(st.delivery[req.file]);
            kind_threshold: rd_mux = st.threshold[req.file];
            kind_eip:       rd_mux = st.eip[req.file];
            kind_eie:       rd_mux = st.eie[req.file];
            default:        rd_mux = '0;    // iprio reads as zero
        endcase
    end

    // read data holds its value over illegal reads
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_rdata <= '0;
        end else if (req.rd) begin
            o_rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_rdata_vld <= 1'b0;
        end else begin
            o_rdata_vld <= i_any_rd;
        end
    end

    // decode must filter unknown offsets
    a_kind_known: assert property (
        @(posedge clk) disable iff (!rstn)
        (req.wr || req.rd) |-> (req.kind != kind_none)
    ) else $error("register strobe with kind_none");

endmodule

`default_nettype wire

/* logic/imsic_csr_decode.sv */
// IMSIC CSR access decode
`timescale 1ns/1ps
`default_nettype none

`include "imsic_config.svh"

module imsic_csr_decode (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  i_csr_wr,
    input  wire                  i_csr_rd,
    input  imsic_pkg::csr_addr_t i_csr_addr,
    input  wire                  i_csr_v,
    input  wire                  i_priv_illegal,
    input  wire [2:0]            i_file_sel,     // one bit wider than the index
    input  imsic_pkg::xlen_t     i_csr_wdata,
    output logic                 o_illegal,
    imsic_csr_if.decode          req
);
    import imsic_pkg::*;

    csr_kind_e kind;
    logic      access;
    logic      file_ok;
    logic      iprio_blocked;
    logic      legal;

    // offset to register kind
    always_comb begin
        kind = kind_none;
        if ((i_csr_addr >= `IMSIC_IPRIO_LO) && (i_csr_addr <= `IMSIC_IPRIO_HI)) begin
            kind = kind_iprio;
        end else begin
            case (i_csr_addr)
                `IMSIC_EIDELIVERY:  kind = kind_delivery;
                `IMSIC_EITHRESHOLD: kind = kind_threshold;
                `IMSIC_EIP0:        kind = kind_eip;
                `IMSIC_EIE0:        kind = kind_eie;
                default:            kind = kind_none; // incl. eip1.., eie1..
            endcase
        end
    end

    assign access        = i_csr_wr | i_csr_rd;
    assign file_ok       = (i_file_sel < 3'(`IMSIC_NR_FILES));
    assign iprio_blocked = (kind == kind_iprio) && i_csr_v; // no iprio in guest mode

    assign legal = !i_priv_illegal && file_ok && !iprio_blocked && (kind != kind_none);

    // forward legal requests only
    assign req.wr    = i_csr_wr & legal;
    assign req.rd    = i_csr_rd & legal;
    assign req.kind  = kind;
    assign req.file  = file_idx_t'(i_file_sel[1:0]);
    assign req.wdata = i_csr_wdata;

    // one cycle pulse after a rejected access
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_illegal <= 1'b0;
        end else begin
            o_illegal <= access & ~legal;
        end
    end

    // caller never issues a write and a read together
    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (!rstn)
        !(i_csr_wr && i_csr_rd)
    ) else $error("csr write and read strobes raised together");

endmodule

`default_nettype wire

/* logic/imsic_ifs.sv */
// IMSIC internal interfaces
`timescale 1ns/1ps
`default_nettype none

`include "imsic_config.svh"

// legal access request, decode to register file
interface imsic_csr_if;
    import imsic_pkg::*;

    logic      wr;      // one cycle, legal only
    logic      rd;
    csr_kind_e kind;
    file_idx_t file;
    xlen_t     wdata;

    modport decode (
        output wr, rd, kind, file, wdata
    );

    modport files (
        input wr, rd, kind, file, wdata
    );
endinterface

// state of all interrupt files
interface imsic_state_if;
    import imsic_pkg::*;

    logic [`IMSIC_NR_FILES-1:0] delivery;
    xlen_t                      threshold [`IMSIC_NR_FILES];
    xlen_t                      eip       [`IMSIC_NR_FILES];
    xlen_t                      eie       [`IMSIC_NR_FILES];

    modport files (
        output delivery, threshold, eip, eie
    );

    modport select (
        input delivery, threshold, eip, eie
    );
endinterface

`default_nettype wire

/* logic/imsic_pkg.sv */
// IMSIC shared types
`default_nettype none

`include "imsic_config.svh"

package imsic_pkg;

    typedef logic [`IMSIC_XLEN-1:0] xlen_t;     // csr data word
    typedef logic [11:0]            csr_addr_t; // indirect csr offset
    typedef logic [1:0]             file_idx_t; // m, s, vs1, vs2
    typedef logic [5:0]             vgein_t;
    typedef logic [`IMSIC_ID_W-1:0] intid_t;

    // identity sits in 26:16 and in 10:0
    typedef logic [31:0]            topei_t;

    // decoded target of an indirect access
    typedef enum logic [2:0] {
        kind_none      = 3'd0,
        kind_iprio     = 3'd1,
        kind_delivery  = 3'd2,
        kind_threshold = 3'd3,
        kind_eip       = 3'd4,
        kind_eie       = 3'd5
    } csr_kind_e;

endpackage

`default_nettype wire

/* logic/imsic_config.svh */
// IMSIC interrupt file configuration
`ifndef IMSIC_CONFIG_SVH
`define IMSIC_CONFIG_SVH

// data and identity widths
`define IMSIC_XLEN          32
`define IMSIC_ID_W          5

// machine, supervisor and the guest files
`define IMSIC_NR_FILES      4
`define IMSIC_NR_VS         2

// indirect csr offsets per the aia layout
`define IMSIC_IPRIO_LO      12'h030
`define IMSIC_IPRIO_HI      12'h03F
`define IMSIC_EIDELIVERY    12'h070
`define IMSIC_EITHRESHOLD   12'h072

// only register 0 exists for eip and eie
`define IMSIC_EIP0          12'h080
`define IMSIC_EIE0          12'h0C0

`endif
